// File: build.f
i2c_pkg.sv
i2c_byte_if.sv
i2c_bit_timer.sv
i2c_byte_shifter.sv
i2c_sequencer.sv
i2c_master_top.sv
i2c_slave_model.sv
i2c_master_assert.sv
tb_i2c_master.sv

// File: i2c_bit_timer.sv
// I2C bit timer: splits each SCL bit into four quarter phases of i2c_clk
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_timer (
	input  wire                i2c_clk,
	input  wire                i_rst_n,
	output logic               o_tick,
	output i2c_pkg::quarter_t  o_quarter
);

	i2c_pkg::div_cnt_t div_cnt;

	wire wrap = (div_cnt == '0);

	// free running, quarter follows every wrap of the divider
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			div_cnt   <= i2c_pkg::div_cnt_t'(i2c_pkg::QUARTER_CYCLES - 1);
			o_tick    <= 1'b0;
			o_quarter <= i2c_pkg::Q_LAST;   // first tick opens quarter 0
		end else if (wrap) begin
			div_cnt   <= i2c_pkg::div_cnt_t'(i2c_pkg::QUARTER_CYCLES - 1);
			o_tick    <= 1'b1;
			o_quarter <= o_quarter + 2'd1;
		end else begin
			div_cnt <= div_cnt - 3'd1;
			o_tick  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: i2c_byte_if.sv
// byte transfer link between the I2C sequencer and the byte shifter
`timescale 1ns/1ps
`default_nettype none

interface i2c_byte_if;

	logic           load;
	i2c_pkg::data_t tx_byte;
	logic           rx_mode;
	logic           ack_level;
	logic           sda_low;
	i2c_pkg::data_t rx_byte;
	logic           ack_seen;
	logic           byte_done;

	modport seq (
		output load,
		output tx_byte,
		output rx_mode,
		output ack_level,
		input  sda_low,
		input  rx_byte,
		input  ack_seen,
		input  byte_done
	);

	modport shf (
		input  load,
		input  tx_byte,
		input  rx_mode,
		input  ack_level,
		output sda_low,
		output rx_byte,
		output ack_seen,
		output byte_done
	);

endinterface

`default_nettype wire

// File: i2c_byte_shifter.sv
// I2C byte shifter: serialises bytes MSB first and collects read bits and acks
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_shifter (
	input  wire                    i2c_clk,
	input  wire                    i_rst_n,
	input  wire                    i_tick,
	input  wire i2c_pkg::quarter_t i_quarter,
	input  wire                    i_sda,
	i2c_byte_if.shf                byte_port
);

	i2c_pkg::data_t tx_sr;
	i2c_pkg::data_t rx_sr;
	i2c_pkg::slot_t slot;
	logic           active;
	logic           ack_r;
	logic           sda_r;

	wire slot_start = i_tick && (i_quarter == i2c_pkg::Q_LOAD);
	wire sample     = i_tick && (i_quarter == i2c_pkg::Q_SAMPLE);
	wire in_ack     = (slot == i2c_pkg::ACK_SLOT);
	wire take       = slot_start && byte_port.load;

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active <= 1'b0;
			slot   <= '0;
			ack_r  <= 1'b0;
			sda_r  <= 1'b0;
		end else begin
			if (take) begin
				active <= 1'b1;
				slot   <= '0;
			end else if (slot_start && active) begin
				if (in_ack)
					active <= 1'b0;
				else
					slot <= slot + 4'd1;
			end
			if (sample && active && in_ack)
				ack_r <= !i_sda;   // target pulled sda low
			if (byte_port.rx_mode)
				sda_r <= active && in_ack && !byte_port.ack_level;
			else
				sda_r <= active && !in_ack && !tx_sr[7];
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (take)
			tx_sr <= byte_port.tx_byte;
		else if (slot_start && active && !in_ack)
			tx_sr <= {tx_sr[6:0], 1'b1};
		if (sample && active && !in_ack)
			rx_sr <= {rx_sr[6:0], i_sda};
	end

	assign byte_port.sda_low   = sda_r;
	assign byte_port.rx_byte   = rx_sr;
	assign byte_port.ack_seen  = ack_r;
	assign byte_port.byte_done = slot_start && active && in_ack;

endmodule

`default_nettype wire

// File: i2c_master_assert.sv
// I2C master checks: reset state, done pulse and SDA edges while SCL is high
`timescale 1ns/1ps
`default_nettype none

module i2c_master_assert (
	input wire i2c_clk,
	input wire i_rst_n,
	input wire i_sda,
	input wire o_busy,
	input wire o_done,
	input wire o_nack,
	input wire o_scl_oe,
	input wire o_sda_oe
);

	int unsigned fail_count;   // failed assertions so far

	a_reset_quiet: assert property (@(posedge i2c_clk)
		$rose(i_rst_n) |-> !o_busy && !o_done && !o_nack && !o_scl_oe && !o_sda_oe)
		else begin
			$error("outputs not quiet after reset");
			fail_count++;
		end

	a_idle_released: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		!o_busy |-> !o_scl_oe && !o_sda_oe)
		else begin
			$error("bus held while idle");
			fail_count++;
		end

	a_done_single: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		o_done |=> !o_done)
		else begin
			$error("o_done longer than one cycle");
			fail_count++;
		end

	a_done_busy_fall: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		o_done |-> !o_busy && $past(o_busy))
		else begin
			$error("o_done without o_busy falling");
			fail_count++;
		end

	a_busy_fall_done: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		$fell(o_busy) |-> o_done)
		else begin
			$error("o_busy fell without o_done");
			fail_count++;
		end

	// with scl high an sda edge is start, restart or stop from the master
	a_sda_scl_high: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		(!o_scl_oe && !$past(o_scl_oe) && $changed(i_sda)) |-> o_busy && (o_sda_oe == !i_sda))
		else begin
			$error("sda moved while scl high outside start or stop");
			fail_count++;
		end

endmodule

bind i2c_master_top i2c_master_assert assert_i (
	.i2c_clk  (i2c_clk),
	.i_rst_n  (i_rst_n),
	.i_sda    (i_sda),
	.o_busy   (o_busy),
	.o_done   (o_done),
	.o_nack   (o_nack),
	.o_scl_oe (o_scl_oe),
	.o_sda_oe (o_sda_oe)
);

`default_nettype wire

// File: i2c_master_top.sv
// I2C register access master: timer, sequencer and shifter with open-drain outputs
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
	input  wire                     i2c_clk,
	input  wire                     i_rst_n,
	input  wire                     i_start,
	input  wire                     i_read,
	input  wire i2c_pkg::dev_addr_t i_dev_addr,
	input  wire i2c_pkg::reg_addr_t i_reg_addr,
	input  wire i2c_pkg::data_t     i_wr_data,
	input  wire                     i_sda,
	output i2c_pkg::data_t          o_rd_data,
	output logic                    o_busy,
	output logic                    o_done,
	output logic                    o_nack,
	output logic                    o_scl_oe,
	output logic                    o_sda_oe
);

	logic              tick;
	i2c_pkg::quarter_t quarter;
	logic              seq_sda_low;

	i2c_byte_if byte_bus ();

	i2c_bit_timer timer_i (
		.i2c_clk   (i2c_clk),
		.i_rst_n   (i_rst_n),
		.o_tick    (tick),
		.o_quarter (quarter)
	);

	i2c_sequencer seq_i (
		.i2c_clk    (i2c_clk),
		.i_rst_n    (i_rst_n),
		.i_tick     (tick),
		.i_quarter  (quarter),
		.i_start    (i_start),
		.i_read     (i_read),
		.i_dev_addr (i_dev_addr),
		.i_reg_addr (i_reg_addr),
		.i_wr_data  (i_wr_data),
		.byte_port  (byte_bus.seq),
		.o_rd_data  (o_rd_data),
		.o_busy     (o_busy),
		.o_done     (o_done),
		.o_nack     (o_nack),
		.o_scl_low  (o_scl_oe),
		.o_sda_low  (seq_sda_low)
	);

	i2c_byte_shifter shf_i (
		.i2c_clk   (i2c_clk),
		.i_rst_n   (i_rst_n),
		.i_tick    (tick),
		.i_quarter (quarter),
		.i_sda     (i_sda),
		.byte_port (byte_bus.shf)
	);

	assign o_sda_oe = seq_sda_low | byte_bus.sda_low;   // either side may pull sda

endmodule

`default_nettype wire

// File: i2c_pkg.sv
// I2C master package: shared widths, quarter-phase timing and sequencer states
`default_nettype none

package i2c_pkg;

	typedef logic [6:0] dev_addr_t;
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] data_t;
	typedef logic [1:0] quarter_t;   // 0,1 scl low; 2,3 scl high
	typedef logic [3:0] slot_t;      // bit slot within one byte
	typedef logic [2:0] div_cnt_t;

	typedef enum logic [3:0] {
		IDLE,
		START,
		SEND_ADDR,
		SEND_REG,
		RESTART,
		SEND_ADDR_RD,
		SEND_DATA,
		RECV_DATA,
		STOP,
		STOP_HOLD
	} seq_state_t;

	localparam int unsigned QUARTER_CYCLES = 5;   // i2c_clk cycles per quarter
	localparam int unsigned BIT_SLOTS = 9;        // 8 data bits + ack

	localparam slot_t ACK_SLOT = slot_t'(BIT_SLOTS - 1);

	localparam quarter_t Q_LOAD = 2'd0;     // bit presented
	localparam quarter_t Q_SAMPLE = 2'd2;   // sda sampled
	localparam quarter_t Q_LAST = 2'd3;

	localparam data_t RD_DUMMY = 8'hFF;     // keeps sda released while receiving

endpackage

`default_nettype wire

// File: i2c_sequencer.sv
// I2C transaction sequencer: start, address, register, data, ack and stop control
`timescale 1ns/1ps
`default_nettype none

module i2c_sequencer (
	input  wire                 i2c_clk,
	input  wire                 i_rst_n,
	input  wire                 i_tick,
	input  wire i2c_pkg::quarter_t  i_quarter,
	input  wire                 i_start,
	input  wire                 i_read,
	input  wire i2c_pkg::dev_addr_t i_dev_addr,
	input  wire i2c_pkg::reg_addr_t i_reg_addr,
	input  wire i2c_pkg::data_t     i_wr_data,
	i2c_byte_if.seq             byte_port,
	output i2c_pkg::data_t      o_rd_data,
	output logic                o_busy,
	output logic                o_done,
	output logic                o_nack,
	output logic                o_scl_low,
	output logic                o_sda_low
);

	i2c_pkg::seq_state_t state, state_nx;
	i2c_pkg::dev_addr_t  req_dev;
	i2c_pkg::reg_addr_t  req_reg;
	i2c_pkg::data_t      req_data;
	i2c_pkg::data_t      tx_c;
	logic                req_read;
	logic                armed;
	logic                load_c;
	logic                sda_c;

	wire slot_start = i_tick && (i_quarter == i2c_pkg::Q_LOAD);
	wire last_tick  = i_tick && (i_quarter == i2c_pkg::Q_LAST);
	wire accept     = (state == i2c_pkg::IDLE) && i_start;
	wire ack_ok     = byte_port.ack_seen;
	wire finish     = (state == i2c_pkg::STOP_HOLD) && last_tick;

	always_comb begin
		state_nx = state;
		load_c   = 1'b0;
		tx_c     = {req_dev, 1'b0};   // address with write bit
		case (state)
			i2c_pkg::IDLE:
				if (i_start)
					state_nx = i2c_pkg::START;
			i2c_pkg::START:
				if (slot_start && armed) begin
					state_nx = i2c_pkg::SEND_ADDR;
					load_c   = 1'b1;
				end
			i2c_pkg::SEND_ADDR:
				if (byte_port.byte_done) begin
					if (!ack_ok) begin
						state_nx = i2c_pkg::STOP;
					end else begin
						state_nx = i2c_pkg::SEND_REG;
						load_c   = 1'b1;
						tx_c     = req_reg;
					end
				end
			i2c_pkg::SEND_REG:
				if (byte_port.byte_done) begin
					if (!ack_ok) begin
						state_nx = i2c_pkg::STOP;
					end else if (req_read) begin
						state_nx = i2c_pkg::RESTART;
					end else begin
						state_nx = i2c_pkg::SEND_DATA;
						load_c   = 1'b1;
						tx_c     = req_data;
					end
				end
			i2c_pkg::RESTART:
				if (slot_start) begin
					state_nx = i2c_pkg::SEND_ADDR_RD;
					load_c   = 1'b1;
					tx_c     = {req_dev, 1'b1};
				end
			i2c_pkg::SEND_ADDR_RD:
				if (byte_port.byte_done) begin
					if (!ack_ok) begin
						state_nx = i2c_pkg::STOP;
					end else begin
						state_nx = i2c_pkg::RECV_DATA;
						load_c   = 1'b1;
						tx_c     = i2c_pkg::RD_DUMMY;
					end
				end
			i2c_pkg::SEND_DATA,
			i2c_pkg::RECV_DATA:
				if (byte_port.byte_done)
					state_nx = i2c_pkg::STOP;
			i2c_pkg::STOP:
				if (last_tick)
					state_nx = i2c_pkg::STOP_HOLD;
			i2c_pkg::STOP_HOLD:
				if (last_tick)
					state_nx = i2c_pkg::IDLE;
			default:
				state_nx = i2c_pkg::IDLE;
		endcase
	end

	// scl follows the quarter inside a bit, held high around start and stop
	always_comb begin
		case (state)
			i2c_pkg::SEND_ADDR,
			i2c_pkg::SEND_REG,
			i2c_pkg::SEND_ADDR_RD,
			i2c_pkg::SEND_DATA,
			i2c_pkg::RECV_DATA,
			i2c_pkg::STOP:    o_scl_low = !i_quarter[1];
			i2c_pkg::RESTART: o_scl_low = (i_quarter == i2c_pkg::Q_LOAD);
			default:          o_scl_low = 1'b0;
		endcase
	end

	// sda held one extra cycle on the leaving tick so scl falls first
	always_comb begin
		case (state)
			i2c_pkg::START:   sda_c = armed && (i_quarter[1] || slot_start);
			i2c_pkg::RESTART: sda_c = i_quarter[1] || slot_start;
			i2c_pkg::STOP:    sda_c = 1'b1;
			default:          sda_c = 1'b0;
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= i2c_pkg::IDLE;
			armed     <= 1'b0;
			o_sda_low <= 1'b0;
			o_busy    <= 1'b0;
			o_done    <= 1'b0;
			o_nack    <= 1'b0;
		end else begin
			state     <= state_nx;
			armed     <= (state_nx == i2c_pkg::START) && (armed || slot_start);
			o_sda_low <= sda_c;
			o_done    <= finish;
			if (accept) begin
				o_busy <= 1'b1;
				o_nack <= 1'b0;
			end else if (finish) begin
				o_busy <= 1'b0;
			end
			if (byte_port.byte_done && !ack_ok && state != i2c_pkg::RECV_DATA)
				o_nack <= 1'b1;   // no ack from target, abort
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (accept) begin
			req_read <= i_read;
			req_dev  <= i_dev_addr;
			req_reg  <= i_reg_addr;
			req_data <= i_wr_data;
		end
		if (state == i2c_pkg::RECV_DATA && byte_port.byte_done)
			o_rd_data <= byte_port.rx_byte;
	end

	assign byte_port.load      = load_c;
	assign byte_port.tx_byte   = tx_c;
	assign byte_port.rx_mode   = (state == i2c_pkg::RECV_DATA);
	assign byte_port.ack_level = 1'b1;   // nack on the single read byte

endmodule

`default_nettype wire

// File: i2c_slave_model.sv
// I2C target model: 256-byte register array behind a programmable device address
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model (
	input  wire       i_scl,
	input  wire       i_sda,
	input  wire [6:0] i_dev_addr,
	output logic      o_sda_low
);

	typedef enum {S_IDLE, S_ADDR, S_REG, S_WDATA, S_RDATA} phase_t;

	logic [7:0] mem [0:255];
	logic [7:0] shift;
	logic [7:0] ptr;
	int         cnt;
	phase_t     phase;

	initial begin
		o_sda_low = 1'b0;
		phase     = S_IDLE;
		cnt       = 0;
		ptr       = 8'h00;
		for (int i = 0; i < 256; i++)
			mem[i] = i[7:0] ^ 8'hA5;
	end

	// start or repeated start
	always @(negedge i_sda) begin
		if (i_scl) begin
			phase     = S_ADDR;
			cnt       = 0;
			o_sda_low = 1'b0;
		end
	end

	always @(posedge i_sda) begin
		if (i_scl) begin   // stop
			phase     = S_IDLE;
			o_sda_low = 1'b0;
		end
	end

	always @(posedge i_scl) begin
		if (phase != S_IDLE && cnt < 8) begin
			if (phase != S_RDATA)
				shift = {shift[6:0], i_sda};
			cnt = cnt + 1;
		end
	end

	// outputs change only while scl is low
	always @(negedge i_scl) begin
		if (phase != S_IDLE) begin
			if (cnt == 8) begin
				cnt = 9;
				case (phase)
					S_ADDR:
						if (shift[7:1] == i_dev_addr) begin
							o_sda_low = 1'b1;
							phase     = shift[0] ? S_RDATA : S_REG;
						end else begin
							phase = S_IDLE;   // not ours, no ack
						end
					S_REG: begin
						ptr       = shift;
						o_sda_low = 1'b1;
						phase     = S_WDATA;
					end
					S_WDATA: begin
						mem[ptr]  = shift;
						ptr       = ptr + 8'd1;
						o_sda_low = 1'b1;
					end
					default: begin
						o_sda_low = 1'b0;   // master nacks the read byte
						phase     = S_IDLE;
					end
				endcase
			end else if (cnt == 9) begin
				cnt       = 0;
				o_sda_low = 1'b0;
				if (phase == S_RDATA) begin
					shift     = mem[ptr];
					o_sda_low = !shift[7];
				end
			end else if (phase == S_RDATA) begin
				o_sda_low = !shift[7 - cnt];
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_i2c_master.sv
// I2C master testbench: random register writes and reads against a target model
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

	localparam int unsigned BIT_CYCLES   = 4 * i2c_pkg::QUARTER_CYCLES;
	localparam int unsigned DONE_TIMEOUT = 48 * BIT_CYCLES;   // longest read is about 41 bits
	localparam logic [6:0]  TARGET_ADDR  = 7'h3A;

	logic        i2c_clk;
	logic        i_rst_n;
	logic        i_start;
	logic        i_read;
	logic [6:0]  i_dev_addr;
	logic [7:0]  i_reg_addr;
	logic [7:0]  i_wr_data;
	wire  [7:0]  o_rd_data;
	wire         o_busy;
	wire         o_done;
	wire         o_nack;
	wire         o_scl_oe;
	wire         o_sda_oe;
	wire         model_sda_low;
	wire         scl_bus;
	wire         sda_bus;
	logic [31:0] lfsr;

	// open drain with pull-ups
	assign scl_bus = !o_scl_oe;
	assign sda_bus = !(o_sda_oe || model_sda_low);

	i2c_master_top dut_i (
		.i2c_clk    (i2c_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_read     (i_read),
		.i_dev_addr (i_dev_addr),
		.i_reg_addr (i_reg_addr),
		.i_wr_data  (i_wr_data),
		.i_sda      (sda_bus),
		.o_rd_data  (o_rd_data),
		.o_busy     (o_busy),
		.o_done     (o_done),
		.o_nack     (o_nack),
		.o_scl_oe   (o_scl_oe),
		.o_sda_oe   (o_sda_oe)
	);

	i2c_slave_model model_i (
		.i_scl      (scl_bus),
		.i_sda      (sda_bus),
		.i_dev_addr (TARGET_ADDR),
		.o_sda_low  (model_sda_low)
	);

	initial begin
		i2c_clk = 1'b0;
		forever #20 i2c_clk = ~i2c_clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic stop_run();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	always @(dut_i.assert_i.fail_count) begin
		if (dut_i.assert_i.fail_count != 0) begin
			$display("a bound bus or status assertion failed");
			stop_run();
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("%s", what);
			stop_run();
		end
	endtask

	// one transaction; poke fires a second start while the first is running
	task automatic run_txn(input logic rd, input logic [6:0] dev, input logic [7:0] reg_a,
			input logic [7:0] data, input logic poke, output logic [7:0] rd_data,
			output logic nack);
		int waited;
		@(negedge i2c_clk);
		i_read     = rd;
		i_dev_addr = dev;
		i_reg_addr = reg_a;
		i_wr_data  = data;
		i_start    = 1'b1;
		@(negedge i2c_clk);
		i_start = 1'b0;
		if (poke) begin
			waited = 0;
			while (waited < BIT_CYCLES) begin
				@(negedge i2c_clk);
				waited++;
			end
			check_true(o_busy, "o_busy low in the middle of a transaction");
			i_read     = !rd;
			i_dev_addr = dev ^ 7'h15;
			i_wr_data  = ~data;
			i_start    = 1'b1;
			@(negedge i2c_clk);
			i_start = 1'b0;
		end
		waited = 0;
		while (!o_done) begin
			if (waited >= DONE_TIMEOUT) begin
				$display("timeout while waiting for o_done");
				stop_run();
			end
			@(negedge i2c_clk);
			waited++;
		end
		rd_data = o_rd_data;
		nack    = o_nack;
	endtask

	initial begin
		logic [31:0] v;
		logic [7:0]  r;
		logic [7:0]  d;
		logic [7:0]  got;
		logic        nack;
		logic [7:0]  wr_reg;
		logic [7:0]  wr_data;
		logic [6:0]  bad_dev;
		logic [7:0]  snap [0:255];
		i_rst_n    = 1'b0;
		i_start    = 1'b0;
		i_read     = 1'b0;
		i_dev_addr = '0;
		i_reg_addr = '0;
		i_wr_data  = '0;
		lfsr       = 32'h67d4_624e;
		repeat (3) @(posedge i2c_clk);
		@(negedge i2c_clk);
		i_rst_n = 1'b1;
		@(negedge i2c_clk);
		check_true(!o_busy && !o_done && !o_nack && !o_scl_oe && !o_sda_oe,
			"outputs not idle after reset");

		for (int k = 0; k < 4; k++) begin   // preload, then read back
			take_bits(8, v);
			r = v[7:0];
			take_bits(8, v);
			d = v[7:0];
			model_i.mem[r] = d;
			run_txn(1'b1, TARGET_ADDR, r, 8'h00, 1'b0, got, nack);
			check_value("o_nack", nack, 1'b0);
			check_value("o_rd_data", got, d);
		end

		take_bits(8, v);
		wr_reg = v[7:0];
		take_bits(8, v);
		wr_data = v[7:0];
		run_txn(1'b0, TARGET_ADDR, wr_reg, wr_data, 1'b0, got, nack);
		check_value("o_nack", nack, 1'b0);
		check_value("model mem", model_i.mem[wr_reg], wr_data);
		run_txn(1'b1, TARGET_ADDR, wr_reg, 8'h00, 1'b0, got, nack);
		check_value("o_nack", nack, 1'b0);
		check_value("o_rd_data", got, wr_data);

		take_bits(7, v);
		bad_dev = (v[6:0] == TARGET_ADDR) ? ~v[6:0] : v[6:0];
		for (int i = 0; i < 256; i++)
			snap[i] = model_i.mem[i];
		take_bits(8, v);
		run_txn(1'b0, bad_dev, wr_reg, v[7:0], 1'b0, got, nack);
		check_value("o_nack", nack, 1'b1);
		@(negedge i2c_clk);
		check_true(!o_scl_oe && !o_sda_oe, "bus not released after a NACK");
		for (int i = 0; i < 256; i++)
			check_value("model mem", model_i.mem[i], snap[i]);

		take_bits(8, v);
		r = v[7:0];
		take_bits(8, v);
		d = v[7:0];
		run_txn(1'b0, TARGET_ADDR, r, d, 1'b1, got, nack);
		check_value("o_nack", nack, 1'b0);
		check_value("model mem", model_i.mem[r], d);
		for (int k = 0; k < 2 * BIT_CYCLES; k++) begin
			@(negedge i2c_clk);
			check_true(!o_busy && !o_done, "start during busy led to a second transaction");
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
